// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= cpu8Tb
FILELIST  ?= tb.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== dv/clockGen.sv ====
// ******************************
// Testbench clock and reset.
// 8 ns clock, reset held low for the first four
// rising edges and released on an edge.
// ******************************
`timescale 1ns/100ps

module clockGen (
	output logic clk,
	output logic rstN
);

	initial begin
		clk  = 1'b0;
		rstN = 1'b0;
		repeat (4) @(posedge clk);
		rstN <= 1'b1;     // Released on the fourth edge
	end

	always #4 clk = ~clk;

endmodule

// ==== dv/cpu8Tb.sv ====
// ******************************
// Testbench for the 8-bit pipelined core.
// Fills a ROM with a directed and a random program, walks it
// with a reference model, then checks the fetch address,
// every write-back and the flags cycle by cycle.
// ******************************
`timescale 1ns/100ps

module cpu8Tb;
	import cpu8Pkg::*;

	localparam int ROM_DEPTH  = 1024;
	localparam int EXP_DEPTH  = ROM_DEPTH + 16;
	localparam int RANDOM_CNT = 200;
	localparam int DIR_LEN    = 37;

	logic   CLK_I;
	logic   nRST_I;
	addrT   instAddr;
	dataT   instData;
	resultT regWrite;
	flagsT  flags;

	dataT   rom [ROM_DEPTH];
	int     runCycles;

	// Expected outputs, indexed by the instAddr value of the cycle
	logic   expValid [EXP_DEPTH];
	logic   expWe    [EXP_DEPTH];
	regIdxT expDest  [EXP_DEPTH];
	dataT   expValue [EXP_DEPTH];
	logic   flagSet  [EXP_DEPTH];
	flagsT  flagNew  [EXP_DEPTH];
	flagsT  expFlags [EXP_DEPTH];

	dataT   regs [7];     // Model registers
	flagsT  curFlags;

	// Loads, moves, INC and DCR with wrap, all ALU forms,
	// a three byte no-op whose trailing bytes look like opcodes,
	// a one byte no-op and a move to register 7
	dataT directedProg [DIR_LEN] = '{
		8'h0E, 8'h12, 8'h16, 8'hFF, 8'h10, 8'h11, 8'hD1, 8'h06, 8'h80,
		8'h82, 8'h89, 8'h14, 8'h92, 8'h9A, 8'h24, 8'h0F, 8'hA9, 8'h34, 8'h40,
		8'hBB, 8'h3C, 8'h55, 8'h44, 8'hAA, 8'hBB, 8'h1E, 8'h86, 8'h20, 8'h21,
		8'hEC, 8'hC5, 8'h80, 8'h45, 8'h00, 8'hF8, 8'h2E, 8'h07
	};

	clockGen i_clockGen (
		.clk  (CLK_I),
		.rstN (nRST_I)
	);

	cpu8Top i_cpu8Top (
		.CLK_I    (CLK_I),
		.nRST_I   (nRST_I),
		.instAddr (instAddr),
		.instData (instData),
		.regWrite (regWrite),
		.flags    (flags)
	);

	assign instData = rom[instAddr[9:0]];     // ROM answers at once

	function automatic logic evenOnes(dataT v);
		int n;
		n = 0;
		for (int i = 0; i < 8; i++)
			if (v[i])
				n++;
		return (n % 2) == 0;
	endfunction

	// Reference ALU on integers, carry is the borrow on subtraction
	task automatic aluModel(input int fn, input int x, input int y, output dataT res,
			output flagsT f);
		int full;
		int cy;
		cy      = curFlags.carry ? 1 : 0;
		f.carry = 1'b0;
		case (fn)
			0, 1: begin
				full    = x + y + ((fn == 1) ? cy : 0);
				f.carry = full > 255;
			end
			4: full = x & y;
			5: full = x ^ y;
			6: full = x | y;
			default: begin     // SUB, SBB, CMP
				full    = x - y - ((fn == 3) ? cy : 0);
				f.carry = full < 0;
			end
		endcase
		res      = full[7:0];
		f.zero   = (res == 8'd0);
		f.sign   = res[7];
		f.parity = evenOnes(res);
	endtask

	// Random kept instructions, about half reading the last destination
	task automatic fillRandom(input int start, output int progEnd);
		int         a;
		int         kind;
		regIdxT     lastDest;
		regIdxT     s;
		regIdxT     dAny;
		regIdxT     dInc;
		logic [2:0] fn;
		a        = start;
		lastDest = 3'd0;
		for (int n = 0; n < RANDOM_CNT; n++) begin
			kind = int'($urandom_range(5, 0));
			fn   = 3'($urandom_range(7, 0));
			s    = ($urandom_range(1, 0) == 1) ? lastDest : regIdxT'($urandom_range(6, 0));
			dAny = regIdxT'($urandom_range(6, 0));
			dInc = (s != 3'd0) ? s : regIdxT'($urandom_range(6, 1));
			case (kind)
				0, 1: begin
					rom[a]   = {2'b00, dInc, 2'b00, (kind == 1)};
					lastDest = dInc;
				end
				2: begin
					rom[a]   = {2'b00, fn, 3'b100};
					lastDest = 3'd0;
				end
				3: begin
					rom[a]   = {2'b10, fn, s};
					lastDest = 3'd0;
				end
				4: begin
					rom[a]   = {2'b00, dAny, 3'b110};
					lastDest = dAny;
				end
				default: begin
					rom[a]   = {2'b11, dAny, s};
					lastDest = dAny;
				end
			endcase
			if (kind == 2 || kind == 4) begin
				rom[a + 1] = dataT'($urandom);
				a += 2;
			end else begin
				a += 1;
			end
		end
		progEnd = a;
	endtask

	// ******************************
	// Reference model in program order
	// ******************************
	task automatic walkProgram();
		int     a;
		int     len;
		dataT   op;
		regIdxT d;
		regIdxT s;
		regIdxT dest;
		dataT   val;
		flagsT  nf;
		logic   we;
		logic   aluUpd;
		for (int c = 0; c < EXP_DEPTH; c++) begin
			expValid[c] = 1'b0;
			flagSet[c]  = 1'b0;
		end
		for (int i = 0; i < 7; i++)
			regs[i] = '0;
		curFlags = '0;
		a        = 0;
		while (a < runCycles) begin
			op     = rom[a];
			d      = op[5:3];
			s      = op[2:0];
			len    = 1;
			we     = 1'b0;
			aluUpd = 1'b0;
			dest   = d;
			val    = '0;
			nf     = curFlags;
			if (op[7:6] == 2'b00 && op[2] && !op[0])
				len = 2;
			else if (op[7:6] == 2'b01 && !op[0])
				len = 3;
			if (op[7:6] == 2'b00 && s == 3'd4) begin     // ALU immediate
				aluModel(int'(d), int'(regs[0]), int'(rom[a + 1]), val, nf);
				aluUpd = 1'b1;
				dest   = 3'd0;
				we     = (d != 3'd7);
			end else if (op[7:6] == 2'b10 && s != 3'd7) begin
				aluModel(int'(d), int'(regs[0]), int'(regs[s]), val, nf);
				aluUpd = 1'b1;
				dest   = 3'd0;
				we     = (d != 3'd7);
			end else if (op[7:6] == 2'b00 && s <= 3'd1 && d != 3'd0 && d != 3'd7) begin
				val = (s == 3'd0) ? regs[d] + 8'd1 : regs[d] - 8'd1;
				we  = 1'b1;
			end else if (op[7:6] == 2'b11 && d != 3'd7 && s != 3'd7) begin
				val = regs[s];
				we  = 1'b1;
			end else if (op[7:6] == 2'b00 && s == 3'd6 && d != 3'd7) begin
				val = rom[a + 1];
				we  = 1'b1;
			end
			if (we)
				regs[dest] = val;
			if (aluUpd) begin
				curFlags       = nf;
				flagSet[a + 7] = 1'b1;     // Visible the cycle before write-back
				flagNew[a + 7] = nf;
			end
			expValid[a + 8] = 1'b1;
			expWe[a + 8]    = we;
			expDest[a + 8]  = dest;
			expValue[a + 8] = val;
			a += len;
		end
		curFlags = '0;
		for (int c = 0; c < EXP_DEPTH; c++) begin
			if (flagSet[c])
				curFlags = flagNew[c];
			expFlags[c] = curFlags;
		end
	endtask

	task automatic reportMismatch(input string name, input int expVal, input int actVal);
		$display("FAIL time=%0t %s expected=%0h actual=%0h", $time, name, expVal, actVal);
		$display("test failed");
		$fatal(1, "Output mismatch on %s", name);
	endtask

	task automatic checkCycle(input int c);
		assert (instAddr == addrT'(c))
			else reportMismatch("instAddr", c, int'(instAddr));
		assert (regWrite.valid == expValid[c])
			else reportMismatch("regWrite.valid", int'(expValid[c]), int'(regWrite.valid));
		if (expValid[c]) begin
			assert (regWrite.writeEnable == expWe[c])
				else reportMismatch("regWrite.writeEnable", int'(expWe[c]),
					int'(regWrite.writeEnable));
			if (expWe[c]) begin
				assert (regWrite.dest == expDest[c])
					else reportMismatch("regWrite.dest", int'(expDest[c]), int'(regWrite.dest));
				assert (regWrite.value == expValue[c])
					else reportMismatch("regWrite.value", int'(expValue[c]),
						int'(regWrite.value));
			end
		end
		assert (flags == expFlags[c])
			else reportMismatch("flags", int'(expFlags[c]), int'(flags));
	endtask

	// ******************************
	// Main sequence
	// ******************************
	initial begin
		int waitCount;
		void'($urandom(8));
		for (int i = 0; i < ROM_DEPTH; i++)
			rom[i] = 8'h00;     // INC A form, a one byte no-op
		for (int i = 0; i < DIR_LEN; i++)
			rom[i] = directedProg[i];
		fillRandom(DIR_LEN, runCycles);
		runCycles += 16;     // Drain the pipeline
		walkProgram();

		waitCount = 0;
		@(negedge CLK_I);
		while (!nRST_I) begin
			waitCount++;
			if (waitCount > 20) begin
				$display("test failed");
				$fatal(1, "Reset was not released within 20 cycles");
			end
			@(negedge CLK_I);
		end

		for (int cycle = 0; cycle < runCycles; cycle++) begin
			if (cycle > 0)
				@(negedge CLK_I);
			checkCycle(cycle);
		end
		$display("test passed");
		$finish;
	end

endmodule

// ==== logic/alu8.sv ====
// ******************************
// 8-bit ALU, purely combinational.
// Eight functions in opcode order with
// parity, sign, zero and carry out.
// ******************************
`timescale 1ns/100ps

module alu8 (
	input  cpu8Pkg::aluOpT  op,
	input  cpu8Pkg::dataT   a,
	input  cpu8Pkg::dataT   b,
	input  logic            carryIn,
	output cpu8Pkg::dataT   result,
	output cpu8Pkg::flagsT  flagsOut
);
	import cpu8Pkg::*;

	logic [8:0] wide;     // Bit 8 is carry or borrow

	always_comb begin
		case (op)
			ALU_ADD: wide = {1'b0, a} + {1'b0, b};
			ALU_ADC: wide = {1'b0, a} + {1'b0, b} + {8'd0, carryIn};
			ALU_SBB: wide = {1'b0, a} - {1'b0, b} - {8'd0, carryIn};
			ALU_AND: wide = {1'b0, a & b};
			ALU_XOR: wide = {1'b0, a ^ b};
			ALU_OR:  wide = {1'b0, a | b};
			default: wide = {1'b0, a} - {1'b0, b};     // SUB and CMP
		endcase
	end

	assign result = wide[7:0];

	assign flagsOut.carry  = wide[8];
	assign flagsOut.zero   = (wide[7:0] == 8'd0);
	assign flagsOut.sign   = wide[7];
	assign flagsOut.parity = ~^wide[7:0];     // Even count of ones

endmodule

// ==== logic/cpu8Pkg.sv ====
// ******************************
// Shared types of the 8-bit pipelined core.
// Widths, opcode field types, ALU and execute encodings,
// and the structs passed between pipeline stages.
// Import into any block that uses them.
// ******************************
package cpu8Pkg;

	localparam int DATA_W    = 8;
	localparam int ADDR_W    = 14;
	localparam int REG_IDX_W = 3;

	typedef logic [DATA_W-1:0]    dataT;
	typedef logic [ADDR_W-1:0]    addrT;
	typedef logic [REG_IDX_W-1:0] regIdxT;     // 0 is A, 7 is unused

	localparam regIdxT ACC_IDX = 3'd0;

	// ALU functions in opcode field order
	typedef enum logic [2:0] {
		ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBB,
		ALU_AND, ALU_XOR, ALU_OR,  ALU_CMP
	} aluOpT;

	typedef enum logic [2:0] {
		EXEC_NONE,
		EXEC_MOVE,     // Operand passes through
		EXEC_INC,
		EXEC_DEC,
		EXEC_ALU
	} execKindT;

	typedef struct packed {
		logic parity;
		logic sign;
		logic zero;
		logic carry;
	} flagsT;

	// Fetch to decode
	typedef struct packed {
		logic valid;
		dataT opcode;
		dataT imm;
	} instrT;

	// Decode to execute
	typedef struct packed {
		logic     valid;
		execKindT kind;
		aluOpT    aluOp;
		regIdxT   dest;
		logic     writeEnable;
		dataT     opA;
		dataT     opB;
	} uopT;

	// Forwarding and write-back
	typedef struct packed {
		logic   valid;
		logic   writeEnable;
		regIdxT dest;
		dataT   value;
	} resultT;

endpackage

// ==== logic/cpu8Top.sv ====
// ******************************
// Top level of the 8-bit pipelined core.
// Fetch, decode, register file and execute blocks.
// Program bytes come in on instData for the address on instAddr;
// results leave on regWrite and flags.
// ******************************
`timescale 1ns/100ps

module cpu8Top (
	input  logic             CLK_I,
	input  logic             nRST_I,
	output cpu8Pkg::addrT    instAddr,
	input  cpu8Pkg::dataT    instData,
	output cpu8Pkg::resultT  regWrite,
	output cpu8Pkg::flagsT   flags
);
	import cpu8Pkg::*;

	instrT  decInstr;
	uopT    execUop;
	regIdxT srcIdx;
	dataT   srcVal;
	dataT   accVal;
	resultT eResult;
	resultT mResult;
	resultT wResult;

	fetchUnit i_fetchUnit (
		.CLK_I    (CLK_I),
		.nRST_I   (nRST_I),
		.instAddr (instAddr),
		.instData (instData),
		.decInstr (decInstr)
	);

	decodeUnit i_decodeUnit (
		.CLK_I    (CLK_I),
		.nRST_I   (nRST_I),
		.decInstr (decInstr),
		.srcIdx   (srcIdx),
		.srcVal   (srcVal),
		.accVal   (accVal),
		.execUop  (execUop)
	);

	regFile i_regFile (
		.CLK_I   (CLK_I),
		.nRST_I  (nRST_I),
		.srcIdx  (srcIdx),
		.srcVal  (srcVal),
		.accVal  (accVal),
		.eResult (eResult),
		.mResult (mResult),
		.wResult (wResult)
	);

	execStage i_execStage (
		.CLK_I   (CLK_I),
		.nRST_I  (nRST_I),
		.execUop (execUop),
		.eResult (eResult),
		.mResult (mResult),
		.wResult (wResult),
		.flags   (flags)
	);

	assign regWrite = wResult;     // Write stage is the result port

endmodule

// ==== logic/decodeUnit.sv ====
// ******************************
// Instruction decode.
// Classifies the opcode, picks the forwarded operands
// and registers one micro-op per cycle for execute.
// Unsupported opcodes leave as no-ops with no write.
// ******************************
`timescale 1ns/100ps

module decodeUnit (
	input  logic             CLK_I,
	input  logic             nRST_I,
	input  cpu8Pkg::instrT   decInstr,
	output cpu8Pkg::regIdxT  srcIdx,
	input  cpu8Pkg::dataT    srcVal,
	input  cpu8Pkg::dataT    accVal,
	output cpu8Pkg::uopT     execUop
);
	import cpu8Pkg::*;

	dataT   opcode;
	regIdxT ddd;
	regIdxT sss;
	logic   isInc;
	logic   isDcr;
	logic   isAluImm;
	logic   isAluReg;
	logic   isLoadImm;
	logic   isMove;
	uopT    nextUop;

	assign opcode = decInstr.opcode;
	assign ddd    = opcode[5:3];
	assign sss    = opcode[2:0];

	// ******************************
	// Opcode classes
	// ******************************
	assign isInc     = (opcode[7:6] == 2'b00) && (sss == 3'b000) && (ddd != 3'd0) && (ddd != 3'd7);
	assign isDcr     = (opcode[7:6] == 2'b00) && (sss == 3'b001) && (ddd != 3'd0) && (ddd != 3'd7);
	assign isAluImm  = (opcode[7:6] == 2'b00) && (sss == 3'b100);
	assign isAluReg  = (opcode[7:6] == 2'b10) && (sss != 3'd7);
	assign isLoadImm = (opcode[7:6] == 2'b00) && (sss == 3'b110) && (ddd != 3'd7);
	assign isMove    = (opcode[7:6] == 2'b11) && (ddd != 3'd7) && (sss != 3'd7);

	// INC and DCR read their target, everything else reads SSS
	assign srcIdx = (opcode[7:6] == 2'b00) ? ddd : sss;

	always_comb begin
		nextUop.valid       = decInstr.valid;
		nextUop.kind        = EXEC_NONE;
		nextUop.aluOp       = aluOpT'(ddd);
		nextUop.dest        = ddd;
		nextUop.writeEnable = 1'b0;
		nextUop.opA         = srcVal;
		nextUop.opB         = decInstr.imm;

		if (isAluImm || isAluReg) begin
			nextUop.kind        = EXEC_ALU;
			nextUop.dest        = ACC_IDX;
			nextUop.opA         = accVal;
			nextUop.opB         = isAluReg ? srcVal : decInstr.imm;
			nextUop.writeEnable = (aluOpT'(ddd) != ALU_CMP);     // CMP sets flags only
		end else if (isInc || isDcr) begin
			nextUop.kind        = isInc ? EXEC_INC : EXEC_DEC;
			nextUop.writeEnable = 1'b1;
		end else if (isMove) begin
			nextUop.kind        = EXEC_MOVE;
			nextUop.writeEnable = 1'b1;
		end else if (isLoadImm) begin
			nextUop.kind        = EXEC_MOVE;
			nextUop.opA         = decInstr.imm;     // Immediate passes through
			nextUop.writeEnable = 1'b1;
		end
	end

	// Decode to execute register
	always_ff @(posedge CLK_I) begin
		if (!nRST_I)
			execUop.valid <= 1'b0;
		else
			execUop <= nextUop;
	end

endmodule

// ==== logic/execStage.sv ====
// ******************************
// Execute stage with the flag register,
// followed by the memory and write stage registers.
// The execute result is combinational; the later two
// stages only carry it along.
// ******************************
`timescale 1ns/100ps

module execStage (
	input  logic             CLK_I,
	input  logic             nRST_I,
	input  cpu8Pkg::uopT     execUop,
	output cpu8Pkg::resultT  eResult,
	output cpu8Pkg::resultT  mResult,
	output cpu8Pkg::resultT  wResult,
	output cpu8Pkg::flagsT   flags
);
	import cpu8Pkg::*;

	dataT  aluResult;
	flagsT aluFlags;
	flagsT flagReg;

	alu8 i_alu8 (
		.op       (execUop.aluOp),
		.a        (execUop.opA),
		.b        (execUop.opB),
		.carryIn  (flagReg.carry),
		.result   (aluResult),
		.flagsOut (aluFlags)
	);

	always_comb begin
		eResult.valid       = execUop.valid;
		eResult.writeEnable = execUop.writeEnable;
		eResult.dest        = execUop.dest;
		case (execUop.kind)
			EXEC_ALU: eResult.value = aluResult;
			EXEC_INC: eResult.value = execUop.opA + 1'b1;
			EXEC_DEC: eResult.value = execUop.opA - 1'b1;
			default:  eResult.value = execUop.opA;     // Move and load
		endcase
	end

	assign flags = flagReg;

	// ******************************
	// Flags and stage registers
	// ******************************
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			flagReg       <= '0;
			mResult.valid <= 1'b0;
			wResult.valid <= 1'b0;
		end else begin
			if (execUop.valid && (execUop.kind == EXEC_ALU))
				flagReg <= aluFlags;
			mResult <= eResult;
			wResult <= mResult;
		end
	end

endmodule

// ==== logic/fetchUnit.sv ====
// ******************************
// Instruction fetch.
// Program counter, bus capture and three fetch stages.
// A length counter hides the trailing bytes of
// two and three byte instructions from decode.
// ******************************
`timescale 1ns/100ps

module fetchUnit (
	input  logic            CLK_I,
	input  logic            nRST_I,
	output cpu8Pkg::addrT   instAddr,
	input  cpu8Pkg::dataT   instData,
	output cpu8Pkg::instrT  decInstr
);
	import cpu8Pkg::*;

	addrT       pc;
	dataT       fetchByte [4];     // 0 is bus capture, 1 to 3 are F1 to F3
	logic [3:0] fetchValid;
	logic [1:0] lengthCount;
	logic       twoByte;
	logic       threeByte;

	assign instAddr = pc;

	// Length decode on the F3 opcode
	assign twoByte   = (fetchByte[3][7:6] == 2'b00) && fetchByte[3][2] && !fetchByte[3][0];
	assign threeByte = (fetchByte[3][7:6] == 2'b01) && !fetchByte[3][0];

	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			pc         <= '0;
			fetchValid <= '0;
		end else begin
			pc         <= pc + 1'b1;     // Wraps at 14 bits
			fetchValid <= {fetchValid[2:0], 1'b1};
		end
	end

	// Byte shifter, no reset on payload
	always_ff @(posedge CLK_I) begin
		fetchByte[0] <= instData;
		for (int i = 1; i < 4; i++) begin
			fetchByte[i] <= fetchByte[i-1];
		end
	end

	// ******************************
	// Decode register and length counter
	// ******************************
	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			lengthCount    <= '0;
			decInstr.valid <= 1'b0;
		end else if (lengthCount == 2'd0) begin
			decInstr.valid  <= fetchValid[3];
			decInstr.opcode <= fetchByte[3];
			decInstr.imm    <= fetchByte[2];
			if (fetchValid[3] && twoByte)
				lengthCount <= 2'd1;
			else if (fetchValid[3] && threeByte)
				lengthCount <= 2'd2;
		end else begin
			lengthCount    <= lengthCount - 1'b1;
			decInstr.valid <= 1'b0;     // Trailing byte, not an opcode
		end
	end

endmodule

// ==== logic/regFile.sv ====
// ******************************
// Register bank of the seven working registers.
// Both read ports forward from execute, memory and write
// results before falling back to the bank.
// Written from the write stage result.
// ******************************
`timescale 1ns/100ps

module regFile (
	input  logic             CLK_I,
	input  logic             nRST_I,
	input  cpu8Pkg::regIdxT  srcIdx,
	output cpu8Pkg::dataT    srcVal,
	output cpu8Pkg::dataT    accVal,
	input  cpu8Pkg::resultT  eResult,
	input  cpu8Pkg::resultT  mResult,
	input  cpu8Pkg::resultT  wResult
);
	import cpu8Pkg::*;

	dataT bank [7];

	function automatic logic hits(resultT res, regIdxT idx);
		return res.valid && res.writeEnable && (res.dest == idx);
	endfunction

	// Youngest match wins
	function automatic dataT readPort(regIdxT idx);
		dataT val;
		if (hits(eResult, idx))
			val = eResult.value;
		else if (hits(mResult, idx))
			val = mResult.value;
		else if (hits(wResult, idx))
			val = wResult.value;
		else
			val = (idx == 3'd7) ? '0 : bank[idx];     // Index 7 has no register
		return val;
	endfunction

	always_comb begin
		srcVal = readPort(srcIdx);
		accVal = readPort(ACC_IDX);
	end

	always_ff @(posedge CLK_I) begin
		if (!nRST_I) begin
			for (int i = 0; i < 7; i++)
				bank[i] <= '0;
		end else if (wResult.valid && wResult.writeEnable && (wResult.dest != 3'd7)) begin
			bank[wResult.dest] <= wResult.value;
		end
	end

endmodule

// ==== tb.f ====
logic/cpu8Pkg.sv
logic/alu8.sv
logic/fetchUnit.sv
logic/decodeUnit.sv
logic/regFile.sv
logic/execStage.sv
logic/cpu8Top.sv
dv/clockGen.sv
dv/cpu8Tb.sv
